/* filelist.f */
+incdir+design
design/core_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/regfile.sv
design/hazard_unit.sv
design/execute_stage.sv
design/mem_stage.sv
design/core.sv
test/tb_clock.sv
test/core_checker.sv
test/core_tb.sv

/* test/core_tb.sv */
`include "core_defs.svh"

module core_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import core_pkg::*;

	localparam int N = 60;	// Program words including the final self-loop
	localparam logic [`PC_W-1:0] LOOP_PC = `PC_W'(4 * (N - 1));

	logic CLK, rst_n;
	logic [`PC_W-1:0] imem_addr;
	logic [31:0] imem_data;
	logic wb_cyc, wb_stb, wb_we, wb_ack;
	logic [`XLEN-1:0] wb_adr, wb_dat_w, wb_dat_r;

	logic [31:0] prog [0:N-1];
	logic [31:0] slave_mem [0:15];
	logic [31:0] lcg_state = 32'hc869_816b;
	logic [`XLEN-1:0] exp_adr [$];
	logic [`XLEN-1:0] exp_dat [$];
	int n_seen = 0;
	int errors = 0;
	bit in_access = 0;
	int wait_cnt;

	tb_clock clk_i (.clk(CLK));

	core dut_i (.*);

	bind core core_checker chk_i (.CLK(CLK), .rst_n(rst_n), .wb_cyc(wb_cyc),
		.wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
		.wb_ack(wb_ack));

	// Words past the program read as NOP
	assign imem_data = (imem_addr[`PC_W-1:2] < N) ? prog[imem_addr[`PC_W-1:2]] : `NOP_INST;

	function automatic int lcg();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return int'(lcg_state[30:16]);	// Upper bits have the better period
	endfunction

	// Initial data memory content per byte address
	function automatic logic [31:0] fill_word(input int a);
		return (a * 32'h9e37_79b9) ^ 32'h0f0f_0000;
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2);
		return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'h23};	// Base always x0
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
	endfunction

	function automatic logic [4:0] pick_reg();
		return 5'(1 + lcg() % 7);	// x1..x7
	endfunction

	// Random forward-only program ending in JAL x0,0
	function automatic void gen_program();
		int i, r, k, sel;
		logic [4:0] rd;
		logic [2:0] f3s [0:5] = '{3'b000, 3'b000, 3'b111, 3'b110, 3'b100, 3'b010};
		i = 0;
		while (i < N - 1) begin
			r = lcg() % 16;
			rd = pick_reg();
			if (r < 5) begin
				sel = lcg() % 6;
				prog[i] = {(sel == 1) ? 7'h20 : 7'h00, pick_reg(), 5'(lcg() % 8),
					f3s[sel], rd, 7'h33};
			end else if (r < 7) begin
				prog[i] = enc_i(12'(lcg() % 4096), 5'(lcg() % 8), 3'b000, rd, 7'h13);
			end else if (r == 7) begin
				prog[i] = {20'(lcg() * 7), rd, 7'h37};	// LUI
			end else if (r < 10) begin
				prog[i] = enc_i(12'(4 * (lcg() % 16)), 5'd0, 3'b010, rd, 7'h03);
				if (i + 1 < N - 1 && lcg() % 2 == 1) begin
					i++;
					prog[i] = enc_s(12'(4 * (lcg() % 16)), rd);	// Load-use pair
				end
			end else if (r < 13) begin
				prog[i] = enc_s(12'(4 * (lcg() % 16)), pick_reg());
			end else if (i + 3 <= N - 1) begin
				k = 1 + lcg() % 2;	// Skip one or two words
				if (r == 15)
					prog[i] = enc_j(21'(4 * (k + 1)), (lcg() % 4 == 0) ? 5'd0 : rd);
				else
					prog[i] = enc_b(13'(4 * (k + 1)), pick_reg(), pick_reg(),
						(r == 14) ? 3'b001 : 3'b000);
			end else begin
				prog[i] = enc_i(12'd1, rd, 3'b000, rd, 7'h13);
			end
			i++;
		end
		prog[N-1] = enc_j(21'd0, 5'd0);
	endfunction

	// Instruction-level model collecting every store in program order
	function automatic void build_expected();
		logic [31:0] x [0:31];
		logic [31:0] dm [0:15];
		logic [31:0] w, a, b, ii, is, ib, ij, addr;
		int idx;
		for (int j = 0; j < 32; j++)
			x[j] = '0;
		for (int j = 0; j < 16; j++)
			dm[j] = fill_word(4 * j);
		idx = 0;
		while (idx != N - 1) begin
			w = prog[idx];
			a = x[w[19:15]];
			b = x[w[24:20]];
			ii = {{20{w[31]}}, w[31:20]};
			is = {{20{w[31]}}, w[31:25], w[11:7]};
			ib = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
			ij = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
			idx++;
			case (w[6:0])
				7'h33: case ({w[30], w[14:12]})
					4'b0000: x[w[11:7]] = a + b;
					4'b1000: x[w[11:7]] = a - b;
					4'b0111: x[w[11:7]] = a & b;
					4'b0110: x[w[11:7]] = a | b;
					4'b0100: x[w[11:7]] = a ^ b;
					default: x[w[11:7]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				endcase
				7'h13: x[w[11:7]] = a + ii;
				7'h37: x[w[11:7]] = {w[31:12], 12'h000};
				7'h03: x[w[11:7]] = dm[(a + ii) >> 2];
				7'h23: begin
					addr = a + is;
					dm[addr >> 2] = b;
					exp_adr.push_back(addr);
					exp_dat.push_back(b);
				end
				7'h63: if ((a == b) != w[12])
					idx = idx - 1 + int'(ib) / 4;
				7'h6f: begin
					x[w[11:7]] = 4 * idx;	// Link is pc+4
					idx = idx - 1 + int'(ij) / 4;
				end
				default: ;
			endcase
			x[0] = '0;
		end
	endfunction

	task automatic fail_stop();
		$display("*** TEST FAILED ***");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_adr(input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] exp);
		if (got !== exp) begin
			$display("[FAIL] t=%0t wb_adr got %h expected %h", $time, got, exp);
			errors++;
			fail_stop();
		end
	endtask

	task automatic check_dat(input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] exp);
		if (got !== exp) begin
			$display("[FAIL] t=%0t wb_dat_w got %h expected %h", $time, got, exp);
			errors++;
			fail_stop();
		end
	endtask

	task automatic check_pc(input logic [`PC_W-1:0] got, input logic [`PC_W-1:0] exp);
		if (got !== exp) begin
			$display("[FAIL] t=%0t imem_addr got %h expected %h", $time, got, exp);
			errors++;
			fail_stop();
		end
	endtask

	// Returns once the final JAL has redirected to itself and older stores are acked
	task automatic wait_self_loop();
		while (imem_addr != LOOP_PC)
			@(negedge CLK);
		while (imem_addr == LOOP_PC)
			@(negedge CLK);
		while (imem_addr != LOOP_PC)
			@(negedge CLK);
	endtask

	// Wishbone slave with 0 to 3 wait cycles, driven on the falling edge
	always @(negedge CLK) begin
		if (!rst_n || wb_ack) begin
			wb_ack = 1'b0;
			in_access = 0;
		end else if (wb_cyc && wb_stb) begin
			if (!in_access) begin
				in_access = 1;
				wait_cnt = lcg() % 4;
			end
			if (wait_cnt == 0) begin
				if (wb_we)
					slave_mem[wb_adr[5:2]] = wb_dat_w;
				else
					wb_dat_r = slave_mem[wb_adr[5:2]];
				wb_ack = 1'b1;
			end else begin
				wait_cnt--;
			end
		end
	end

	// Acked writes checked in program order
	always @(posedge CLK) begin
		if (rst_n && wb_cyc && wb_stb && wb_we && wb_ack) begin
			if (n_seen >= exp_adr.size()) begin
				$display("Store to %h seen after all expected stores", wb_adr);
				errors++;
				fail_stop();
			end else begin
				check_adr(wb_adr, exp_adr[n_seen]);
				check_dat(wb_dat_w, exp_dat[n_seen]);
				n_seen++;
			end
		end
	end

	// Protocol failures counted by the bound checker
	always @(dut_i.chk_i.fail_cnt) begin
		if (dut_i.chk_i.fail_cnt != 0) begin
			$display("Wishbone protocol assertion failed at t=%0t", $time);
			errors++;
			fail_stop();
		end
	end

	initial begin
		repeat (10 + N * 12) @(posedge CLK);
		$display("Timeout: only %0d of %0d expected stores appeared", n_seen, exp_adr.size());
		fail_stop();
	end

	initial begin
		rst_n = 1'b0;
		wb_ack = 1'b0;
		wb_dat_r = '0;
		for (int j = 0; j < 16; j++)
			slave_mem[j] = fill_word(4 * j);
		gen_program();
		build_expected();
		repeat (10) @(negedge CLK);
		check_pc(imem_addr, `RESET_PC);	// First fetch address
		rst_n = 1'b1;
		wait (n_seen == exp_adr.size());
		@(negedge CLK);
		wait_self_loop();	// A store beyond the model shows up before this returns
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			fail_stop();
		end
	end

endmodule

/* test/core_checker.sv */
`include "core_defs.svh"

module core_checker (
	input logic CLK,
	input logic rst_n,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [`XLEN-1:0] wb_adr,
	input logic [`XLEN-1:0] wb_dat_w,
	input logic wb_ack
);
	timeunit 1ns;
	timeprecision 100ps;

	logic clocked = 1'b0;	// Bus outputs unknown before the first edge
	int fail_cnt = 0;	// Assertion failures so far

	always @(posedge CLK)
		clocked <= 1'b1;

	a_stb_cyc: assert property (@(posedge CLK) disable iff (!rst_n) wb_stb |-> wb_cyc)
		else begin
			$error("stb high without cyc");
			fail_cnt++;
		end

	// Request held until ack
	a_hold: assert property (@(posedge CLK) disable iff (!rst_n)
		wb_stb && !wb_ack |=> $stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_w))
		else begin
			$error("request changed before ack");
			fail_cnt++;
		end

	a_cyc_drop: assert property (@(posedge CLK) disable iff (!rst_n)
		wb_cyc && wb_ack |=> !wb_cyc)
		else begin
			$error("cyc still high after ack");
			fail_cnt++;
		end

	a_reset_idle: assert property (@(posedge CLK) clocked && !rst_n |-> !wb_cyc && !wb_stb)
		else begin
			$error("bus cycle during reset");
			fail_cnt++;
		end

endmodule

/* test/tb_clock.sv */
module tb_clock (
	output logic clk
);
	timeunit 1ns;
	timeprecision 100ps;

	initial clk = 1'b0;

	always #2 clk = ~clk;	// 4 ns period

endmodule

/* design/core.sv */
`include "core_defs.svh"

module core (
	input  logic CLK,
	input  logic rst_n,

	// Instruction port, combinational read
	output logic [`PC_W-1:0] imem_addr,
	input  logic [31:0] imem_data,

	// Wishbone classic data master
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output logic [`XLEN-1:0] wb_adr,
	output logic [`XLEN-1:0] wb_dat_w,
	input  logic [`XLEN-1:0] wb_dat_r,
	input  logic wb_ack
);
	import core_pkg::*;

	// IF/ID
	logic [31:0] if_id_inst;
	logic [`PC_W-1:0] if_id_pc;

	// Register file ports, ID side
	logic [`REG_AW-1:0] rs1_addr, rs2_addr;
	logic [`XLEN-1:0] rs1_val, rs2_val;

	// Stage registers
	id_exe_t id_exe;
	exe_mem_t exe_mem;
	mem_wb_t mem_wb;

	// Hazard and control
	fwd_sel_e fwd_a, fwd_b;
	logic stall_front;		// Load-use hold of PC and IF/ID
	logic flush_front;		// Branch/JAL kill of IF/ID and ID/EXE
	logic mem_busy;			// Wishbone access still open
	logic redirect;
	logic [`PC_W-1:0] redirect_pc;
	logic [`XLEN-1:0] mem_fwd_val;	// MEM stage result for forwarding

	fetch_stage u_fetch (
		.CLK(CLK),
		.rst_n(rst_n),
		.imem_data(imem_data),
		.stall_front(stall_front),
		.flush_front(flush_front),
		.mem_busy(mem_busy),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.imem_addr(imem_addr),
		.if_id_inst(if_id_inst),
		.if_id_pc(if_id_pc)
	);

	decode_stage u_decode (
		.CLK(CLK),
		.rst_n(rst_n),
		.if_id_inst(if_id_inst),
		.if_id_pc(if_id_pc),
		.rs1_val(rs1_val),
		.rs2_val(rs2_val),
		.stall_front(stall_front),
		.flush_front(flush_front),
		.mem_busy(mem_busy),
		.rs1_addr(rs1_addr),
		.rs2_addr(rs2_addr),
		.id_exe(id_exe)
	);

	regfile u_regfile (
		.CLK(CLK),
		.rst_n(rst_n),
		.rs1_addr(rs1_addr),
		.rs2_addr(rs2_addr),
		.wb(mem_wb),	// WB write port
		.rs1_val(rs1_val),
		.rs2_val(rs2_val)
	);

	hazard_unit u_hazard (
		.rs1_addr(rs1_addr),
		.rs2_addr(rs2_addr),
		.id_exe(id_exe),
		.exe_mem(exe_mem),
		.mem_wb(mem_wb),
		.redirect(redirect),
		.mem_busy(mem_busy),
		.fwd_a(fwd_a),
		.fwd_b(fwd_b),
		.stall_front(stall_front),
		.flush_front(flush_front)
	);

	execute_stage u_execute (
		.CLK(CLK),
		.rst_n(rst_n),
		.id_exe(id_exe),
		.fwd_a(fwd_a),
		.fwd_b(fwd_b),
		.mem_fwd_val(mem_fwd_val),
		.mem_wb(mem_wb),
		.mem_busy(mem_busy),
		.exe_mem(exe_mem),
		.redirect(redirect),
		.redirect_pc(redirect_pc)
	);

	mem_stage u_mem (
		.CLK(CLK),
		.rst_n(rst_n),
		.exe_mem(exe_mem),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.mem_busy(mem_busy),
		.mem_fwd_val(mem_fwd_val),
		.mem_wb(mem_wb)
	);

endmodule

/* design/mem_stage.sv */
`include "core_defs.svh"

module mem_stage (
	input  logic CLK,
	input  logic rst_n,
	input  core_pkg::exe_mem_t exe_mem,
	input  logic [`XLEN-1:0] wb_dat_r,
	input  logic wb_ack,
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output logic [`XLEN-1:0] wb_adr,
	output logic [`XLEN-1:0] wb_dat_w,
	output logic mem_busy,
	output logic [`XLEN-1:0] mem_fwd_val,
	output core_pkg::mem_wb_t mem_wb
);
	import core_pkg::*;

	typedef enum logic {IDLE, WAIT_ACK} state_e;

	state_e state;
	logic is_mem;
	logic ack_q;	// Access ended last cycle, bus must idle once

	assign is_mem = exe_mem.mem_read || exe_mem.mem_write;

	// Cycle opens as soon as LW/SW sits in MEM, unless right after an ack
	assign wb_cyc = (state == WAIT_ACK) || (is_mem && !ack_q);
	assign wb_stb = wb_cyc;
	assign wb_we = exe_mem.mem_write;
	assign wb_adr = {exe_mem.alu_res[`XLEN-1:2], 2'b00};	// Word aligned
	assign wb_dat_w = exe_mem.store_val;

	assign mem_busy = is_mem && !(wb_cyc && wb_ack);	// Released on the ack cycle

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			state <= IDLE;
			ack_q <= 1'b0;
		end else begin
			ack_q <= wb_cyc && wb_ack;
			case (state)
				IDLE:     if (wb_cyc && !wb_ack) state <= WAIT_ACK;
				WAIT_ACK: if (wb_ack) state <= IDLE;
				default:  state <= IDLE;
			endcase
		end
	end

	always_comb begin
		case (exe_mem.wb_src)
			SRC_LOAD: mem_fwd_val = wb_dat_r;
			SRC_PC4:  mem_fwd_val = {{(`XLEN-`PC_W){1'b0}}, exe_mem.pc4};
			default:  mem_fwd_val = exe_mem.alu_res;
		endcase
	end

	// MEM/WB, bubble while the access is open
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			mem_wb.reg_write <= 1'b0;
		end else begin
			mem_wb.reg_write <= exe_mem.reg_write && !mem_busy;
			mem_wb.rd <= exe_mem.rd;
			mem_wb.wr_data <= mem_fwd_val;
		end
	end

endmodule

/* design/execute_stage.sv */
`include "core_defs.svh"

module execute_stage (
	input  logic CLK,
	input  logic rst_n,
	input  core_pkg::id_exe_t id_exe,
	input  core_pkg::fwd_sel_e fwd_a,
	input  core_pkg::fwd_sel_e fwd_b,
	input  logic [`XLEN-1:0] mem_fwd_val,
	input  core_pkg::mem_wb_t mem_wb,
	input  logic mem_busy,
	output core_pkg::exe_mem_t exe_mem,
	output logic redirect,
	output logic [`PC_W-1:0] redirect_pc
);
	import core_pkg::*;

	logic [`XLEN-1:0] a_live, b_live;	// After forwarding mux
	logic [`XLEN-1:0] a_hold, b_hold;
	logic held;
	logic [`XLEN-1:0] op_a, op_b, alu_b, alu_res;
	logic taken;
	exe_mem_t exe_mem_d;

	function automatic logic [`XLEN-1:0] fwd_mux(input fwd_sel_e sel,
			input logic [`XLEN-1:0] reg_val);
		case (sel)
			FWD_MEM: return mem_fwd_val;
			FWD_WB:  return mem_wb.wr_data;
			default: return reg_val;
		endcase
	endfunction

	always_comb begin
		a_live = fwd_mux(fwd_a, id_exe.rs1_val);
		b_live = fwd_mux(fwd_b, id_exe.rs2_val);
	end

	// MEM/WB drains to a bubble during a bus stall, so the WB-forwarded
	// operands are frozen on the first stalled cycle and reused until release
	always_ff @(posedge CLK) begin
		if (!rst_n)
			held <= 1'b0;
		else
			held <= mem_busy;
	end

	always_ff @(posedge CLK) begin
		if (mem_busy && !held) begin
			a_hold <= a_live;
			b_hold <= b_live;
		end
	end

	assign op_a = held ? a_hold : a_live;
	assign op_b = held ? b_hold : b_live;
	assign alu_b = id_exe.ctrl.use_imm ? id_exe.imm : op_b;

	always_comb begin
		case (id_exe.ctrl.alu_op)
			ALU_ADD: alu_res = op_a + alu_b;
			ALU_SUB: alu_res = op_a - alu_b;
			ALU_AND: alu_res = op_a & alu_b;
			ALU_OR:  alu_res = op_a | alu_b;
			ALU_XOR: alu_res = op_a ^ alu_b;
			ALU_SLT: alu_res = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
			default: alu_res = alu_b;	// PASS_B for LUI
		endcase
	end

	// BEQ on equal, BNE on not equal
	assign taken = id_exe.ctrl.is_branch && ((op_a == op_b) != id_exe.ctrl.branch_ne);
	assign redirect = taken || id_exe.ctrl.is_jal;
	assign redirect_pc = id_exe.pc + id_exe.imm[`PC_W-1:0];	// Same adder for B and J

	always_comb begin
		exe_mem_d.reg_write = id_exe.ctrl.reg_write;
		exe_mem_d.mem_read = id_exe.ctrl.mem_read;
		exe_mem_d.mem_write = id_exe.ctrl.mem_write;
		exe_mem_d.wb_src = id_exe.ctrl.wb_src;
		exe_mem_d.rd = id_exe.rd;
		exe_mem_d.alu_res = alu_res;
		exe_mem_d.store_val = op_b;	// SW data is rs2
		exe_mem_d.pc4 = id_exe.pc + `PC_W'(4);
	end

	// EXE/MEM
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			exe_mem.reg_write <= 1'b0;
			exe_mem.mem_read <= 1'b0;
			exe_mem.mem_write <= 1'b0;
		end else if (!mem_busy) begin
			exe_mem <= exe_mem_d;
		end
	end

endmodule

/* design/hazard_unit.sv */
`include "core_defs.svh"

module hazard_unit (
	input  logic [`REG_AW-1:0] rs1_addr,	// Sources of the instruction in ID
	input  logic [`REG_AW-1:0] rs2_addr,
	input  core_pkg::id_exe_t id_exe,
	input  core_pkg::exe_mem_t exe_mem,
	input  core_pkg::mem_wb_t mem_wb,
	input  logic redirect,
	input  logic mem_busy,
	output core_pkg::fwd_sel_e fwd_a,
	output core_pkg::fwd_sel_e fwd_b,
	output logic stall_front,
	output logic flush_front
);
	import core_pkg::*;

	logic load_use;

	// MEM is younger than WB so it is checked first
	function automatic fwd_sel_e pick_src(input logic [`REG_AW-1:0] rs);
		if (rs == '0)
			return FWD_REG;
		if (exe_mem.reg_write && exe_mem.rd == rs)
			return FWD_MEM;
		if (mem_wb.reg_write && mem_wb.rd == rs)
			return FWD_WB;
		return FWD_REG;
	endfunction

	always_comb begin
		fwd_a = pick_src(id_exe.rs1);
		fwd_b = pick_src(id_exe.rs2);
	end

	// LW in EXE, consumer in ID: data only exists after MEM
	assign load_use = id_exe.ctrl.mem_read && id_exe.rd != '0
		&& (id_exe.rd == rs1_addr || id_exe.rd == rs2_addr);

	assign stall_front = load_use;

	// Held off during a bus access, branch stays in EXE until then
	assign flush_front = redirect && !mem_busy;

endmodule

/* design/regfile.sv */
`include "core_defs.svh"

module regfile (
	input  logic CLK,
	input  logic rst_n,
	input  logic [`REG_AW-1:0] rs1_addr,
	input  logic [`REG_AW-1:0] rs2_addr,
	input  core_pkg::mem_wb_t wb,
	output logic [`XLEN-1:0] rs1_val,
	output logic [`XLEN-1:0] rs2_val
);

	logic [`XLEN-1:0] regs [1:31];	// x0 has no storage

	// Same-cycle WB write shows through to the reads
	function automatic logic [`XLEN-1:0] read_reg(input logic [`REG_AW-1:0] a);
		if (a == '0)
			return '0;
		if (wb.reg_write && wb.rd == a)
			return wb.wr_data;
		return regs[a];
	endfunction

	always_comb begin
		rs1_val = read_reg(rs1_addr);
		rs2_val = read_reg(rs2_addr);
	end

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (wb.reg_write && wb.rd != '0) begin
			regs[wb.rd] <= wb.wr_data;
		end
	end

endmodule

/* design/decode_stage.sv */
`include "core_defs.svh"

module decode_stage (
	input  logic CLK,
	input  logic rst_n,
	input  logic [31:0] if_id_inst,
	input  logic [`PC_W-1:0] if_id_pc,
	input  logic [`XLEN-1:0] rs1_val,
	input  logic [`XLEN-1:0] rs2_val,
	input  logic stall_front,
	input  logic flush_front,
	input  logic mem_busy,
	output logic [`REG_AW-1:0] rs1_addr,
	output logic [`REG_AW-1:0] rs2_addr,
	output core_pkg::id_exe_t id_exe
);
	import core_pkg::*;

	// All enables clear, behaves as ADDI x0,x0,0
	localparam ctrl_t CTRL_NOP = '{alu_op: ALU_ADD, wb_src: SRC_ALU, default: 1'b0};

	opcode_e opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [`XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
	ctrl_t ctrl;
	logic [`XLEN-1:0] imm;
	id_exe_t id_exe_d;

	assign opcode = opcode_e'(if_id_inst[6:0]);
	assign funct3 = if_id_inst[14:12];
	assign funct7 = if_id_inst[31:25];
	assign rs1_addr = if_id_inst[19:15];
	assign rs2_addr = if_id_inst[24:20];

	// Immediate formats, all sign-extended from bit 31
	assign imm_i = {{20{if_id_inst[31]}}, if_id_inst[31:20]};
	assign imm_s = {{20{if_id_inst[31]}}, if_id_inst[31:25], if_id_inst[11:7]};
	assign imm_b = {{19{if_id_inst[31]}}, if_id_inst[31], if_id_inst[7],
		if_id_inst[30:25], if_id_inst[11:8], 1'b0};
	assign imm_u = {if_id_inst[31:12], 12'h000};
	assign imm_j = {{11{if_id_inst[31]}}, if_id_inst[31], if_id_inst[19:12],
		if_id_inst[20], if_id_inst[30:21], 1'b0};

	always_comb begin
		ctrl = CTRL_NOP;	// Anything unsupported stays a bubble
		imm = imm_i;
		case (opcode)
			OPC_OP: begin
				ctrl.reg_write = 1'b1;
				case ({funct7, funct3})
					{7'h00, 3'b000}: ctrl.alu_op = ALU_ADD;
					{7'h20, 3'b000}: ctrl.alu_op = ALU_SUB;
					{7'h00, 3'b111}: ctrl.alu_op = ALU_AND;
					{7'h00, 3'b110}: ctrl.alu_op = ALU_OR;
					{7'h00, 3'b100}: ctrl.alu_op = ALU_XOR;
					{7'h00, 3'b010}: ctrl.alu_op = ALU_SLT;
					default: ctrl = CTRL_NOP;
				endcase
			end
			OPC_OP_IMM: if (funct3 == 3'b000) begin	// ADDI only
				ctrl.use_imm = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			OPC_LUI: begin
				ctrl.alu_op = ALU_PASS_B;	// rd = imm
				ctrl.use_imm = 1'b1;
				ctrl.reg_write = 1'b1;
				imm = imm_u;
			end
			OPC_LOAD: if (funct3 == 3'b010) begin	// LW
				ctrl.use_imm = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.mem_read = 1'b1;
				ctrl.wb_src = SRC_LOAD;
			end
			OPC_STORE: if (funct3 == 3'b010) begin	// SW
				ctrl.use_imm = 1'b1;
				ctrl.mem_write = 1'b1;
				imm = imm_s;
			end
			OPC_BRANCH: if (funct3[2:1] == 2'b00) begin	// BEQ, BNE
				ctrl.is_branch = 1'b1;
				ctrl.branch_ne = funct3[0];
				imm = imm_b;
			end
			OPC_JAL: begin
				ctrl.is_jal = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.wb_src = SRC_PC4;	// Link
				imm = imm_j;
			end
			default: ;
		endcase
	end

	always_comb begin
		id_exe_d.ctrl = ctrl;
		id_exe_d.pc = if_id_pc;
		id_exe_d.rs1 = rs1_addr;
		id_exe_d.rs2 = rs2_addr;
		id_exe_d.rd = if_id_inst[11:7];
		id_exe_d.rs1_val = rs1_val;
		id_exe_d.rs2_val = rs2_val;
		id_exe_d.imm = imm;
	end

	// ID/EXE, only ctrl needs clearing for a bubble
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			id_exe.ctrl <= CTRL_NOP;
		end else if (!mem_busy) begin
			id_exe <= id_exe_d;
			if (stall_front || flush_front)
				id_exe.ctrl <= CTRL_NOP;
		end
	end

endmodule

/* design/fetch_stage.sv */
`include "core_defs.svh"

module fetch_stage (
	input  logic CLK,
	input  logic rst_n,
	input  logic [31:0] imem_data,
	input  logic stall_front,
	input  logic flush_front,
	input  logic mem_busy,
	input  logic redirect,
	input  logic [`PC_W-1:0] redirect_pc,
	output logic [`PC_W-1:0] imem_addr,
	output logic [31:0] if_id_inst,
	output logic [`PC_W-1:0] if_id_pc
);

	logic [`PC_W-1:0] pc;

	assign imem_addr = pc;	// Fetch address straight from PC

	// PC: back-pressure first, then redirect, then load-use hold
	always_ff @(posedge CLK) begin
		if (!rst_n)
			pc <= `RESET_PC;
		else if (mem_busy)
			pc <= pc;
		else if (redirect)
			pc <= redirect_pc;	// Target fetched next cycle
		else if (!stall_front)
			pc <= pc + `PC_W'(4);
	end

	// IF/ID
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			if_id_inst <= `NOP_INST;
		end else if (!mem_busy) begin
			if (flush_front) begin
				if_id_inst <= `NOP_INST;	// Wrong-path word dropped
			end else if (!stall_front) begin
				if_id_inst <= imem_data;
				if_id_pc <= pc;
			end
		end
	end

endmodule

/* design/core_pkg.sv */
`include "core_defs.svh"

package core_pkg;

	// RV32I major opcodes of the subset
	typedef enum logic [6:0] {
		OPC_OP     = 7'h33,
		OPC_OP_IMM = 7'h13,
		OPC_LUI    = 7'h37,
		OPC_LOAD   = 7'h03,
		OPC_STORE  = 7'h23,
		OPC_BRANCH = 7'h63,
		OPC_JAL    = 7'h6f
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_PASS_B
	} alu_op_e;

	// Writeback data source
	typedef enum logic [1:0] {SRC_ALU, SRC_LOAD, SRC_PC4} wb_src_e;

	// Operand source in EXE
	typedef enum logic [1:0] {FWD_REG, FWD_MEM, FWD_WB} fwd_sel_e;

	typedef struct packed {
		alu_op_e alu_op;
		logic use_imm;		// imm replaces rs2 at ALU B
		logic reg_write;
		logic mem_read;
		logic mem_write;
		logic is_branch;
		logic branch_ne;	// BNE when set, else BEQ
		logic is_jal;
		wb_src_e wb_src;
	} ctrl_t;

	typedef struct packed {
		ctrl_t ctrl;
		logic [`PC_W-1:0] pc;
		logic [`REG_AW-1:0] rs1;
		logic [`REG_AW-1:0] rs2;
		logic [`REG_AW-1:0] rd;
		logic [`XLEN-1:0] rs1_val;
		logic [`XLEN-1:0] rs2_val;
		logic [`XLEN-1:0] imm;
	} id_exe_t;

	typedef struct packed {
		logic reg_write;
		logic mem_read;
		logic mem_write;
		wb_src_e wb_src;
		logic [`REG_AW-1:0] rd;
		logic [`XLEN-1:0] alu_res;	// Also the data address
		logic [`XLEN-1:0] store_val;
		logic [`PC_W-1:0] pc4;		// Link value for JAL
	} exe_mem_t;

	typedef struct packed {
		logic reg_write;
		logic [`REG_AW-1:0] rd;
		logic [`XLEN-1:0] wr_data;
	} mem_wb_t;

endpackage

/* design/core_defs.svh */
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Datapath width
`define XLEN 32

// Instruction address width, 4 KB fetch space
`define PC_W 12

// x0..x31
`define REG_AW 5

// First fetch address after reset
`define RESET_PC 12'h000

// ADDI x0,x0,0
`define NOP_INST 32'h0000_0013

`endif
